// File: include/roce_consts.svh
`ifndef ROCE_CONSTS_SVH
`define ROCE_CONSTS_SVH

// stream widths, one 14-byte header fits in a single beat
`define ROCE_AXIS_DATA_W 128
`define ROCE_AXIS_KEEP_W 16

// AXI-Lite
`define ROCE_AXIL_ADDR_W 32
`define ROCE_AXIL_DATA_W 32

// register offsets
`define ROCE_REG_LMAC_LO 32'h0000_0000
`define ROCE_REG_LMAC_HI 32'h0000_0004
`define ROCE_REG_RMAC_LO 32'h0000_0008
`define ROCE_REG_RMAC_HI 32'h0000_000C

// ethernet framing
`define ROCE_ETHERTYPE_IPV4 16'h0800
`define ROCE_ETH_HDR_BYTES 14

`endif

// File: src/stream_pkg.sv
`include "roce_consts.svh"

package stream_pkg;

  // data and byte enables of one stream beat
  typedef logic [`ROCE_AXIS_DATA_W-1:0] axis_data_t;
  typedef logic [`ROCE_AXIS_KEEP_W-1:0] axis_keep_t;

  // one beat as held in a register stage
  typedef struct packed {
    axis_data_t data;
    axis_keep_t keep;
    logic       last;
  } axis_beat_t;

  // byte lane k sits at bits 8k+7:8k
  localparam int lane_bits = 8;

  // tkeep width follows from the data width
  localparam int lanes = `ROCE_AXIS_DATA_W / lane_bits;

endpackage : stream_pkg

// File: src/csr_pkg.sv
package csr_pkg;

  typedef logic [47:0] mac_addr_t;

  // AXI-Lite response codes in use
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_t;

  // decoded register
  typedef enum logic [2:0] {
    REG_LMAC_LO,
    REG_LMAC_HI,
    REG_RMAC_LO,
    REG_RMAC_HI,
    REG_NONE
  } csr_reg_e;

  // addresses as seen on the wire, most significant byte in lane 0
  typedef struct packed {
    mac_addr_t local_mac;
    mac_addr_t remote_mac;
  } net_cfg_t;

  // width of the stored high halves
  localparam int mac_hi_bits = 16;

  // lower 32 bits live in the LO register
  localparam int mac_lo_bits = 32;

endpackage : csr_pkg

// File: src/axis_if.sv
`timescale 1ns/1ns

interface axis_if;

  import stream_pkg::*;

  axis_data_t tdata;
  axis_keep_t tkeep;
  logic       tlast;
  logic       tvalid;
  logic       tready;

  modport source (
    output tdata, tkeep, tlast, tvalid,
    input  tready
  );

  modport sink (
    input  tdata, tkeep, tlast, tvalid,
    output tready
  );

endinterface : axis_if

// File: src/roce_csr.sv
`timescale 1ns/1ns
`include "roce_consts.svh"

module roce_csr (
  input  logic                             axis_aclk_i,
  input  logic                             reset_i,
  input  logic                             s_axil_awvalid_i,
  input  logic [`ROCE_AXIL_ADDR_W-1:0]     s_axil_awaddr_i,
  output logic                             s_axil_awready_o,
  input  logic                             s_axil_wvalid_i,
  input  logic [`ROCE_AXIL_DATA_W-1:0]     s_axil_wdata_i,
  input  logic [`ROCE_AXIL_DATA_W/8-1:0]   s_axil_wstrb_i,
  output logic                             s_axil_wready_o,
  output logic                             s_axil_bvalid_o,
  output logic [1:0]                       s_axil_bresp_o,
  input  logic                             s_axil_bready_i,
  input  logic                             s_axil_arvalid_i,
  input  logic [`ROCE_AXIL_ADDR_W-1:0]     s_axil_araddr_i,
  output logic                             s_axil_arready_o,
  output logic                             s_axil_rvalid_o,
  output logic [`ROCE_AXIL_DATA_W-1:0]     s_axil_rdata_o,
  output logic [1:0]                       s_axil_rresp_o,
  input  logic                             s_axil_rready_i,
  output csr_pkg::net_cfg_t                cfg_o
);

  import csr_pkg::*;

  logic [mac_lo_bits-1:0] lmac_lo, rmac_lo;
  logic [mac_hi_bits-1:0] lmac_hi, rmac_hi;
  logic                   wr_en, rd_en;
  csr_reg_e               wr_sel, rd_sel;
  logic [`ROCE_AXIL_DATA_W-1:0] wr_merged;
  logic                   bvalid_q, rvalid_q;
  axil_resp_t             bresp_q, rresp_q;
  logic [`ROCE_AXIL_DATA_W-1:0] rdata_q;

  function automatic csr_reg_e decode(input logic [`ROCE_AXIL_ADDR_W-1:0] addr);
    case (addr)
      `ROCE_REG_LMAC_LO: return REG_LMAC_LO;
      `ROCE_REG_LMAC_HI: return REG_LMAC_HI;
      `ROCE_REG_RMAC_LO: return REG_RMAC_LO;
      `ROCE_REG_RMAC_HI: return REG_RMAC_HI;
      default:           return REG_NONE;
    endcase
  endfunction

  // high halves read back zero-extended
  function automatic logic [`ROCE_AXIL_DATA_W-1:0] read_reg(input csr_reg_e sel);
    case (sel)
      REG_LMAC_LO: return lmac_lo;
      REG_LMAC_HI: return {16'h0000, lmac_hi};
      REG_RMAC_LO: return rmac_lo;
      REG_RMAC_HI: return {16'h0000, rmac_hi};
      default:     return '0;
    endcase
  endfunction

  // most significant byte goes to lane 0
  function automatic mac_addr_t to_net(input mac_addr_t mac);
    mac_addr_t res;
    for (int b = 0; b < 6; b++) begin
      res[8*b +: 8] = mac[8*(5-b) +: 8];
    end
    return res;
  endfunction

  // one write and one read in flight at most
  assign wr_en = s_axil_awvalid_i & s_axil_wvalid_i & ~bvalid_q;
  assign rd_en = s_axil_arvalid_i & ~rvalid_q;
  assign wr_sel = decode(s_axil_awaddr_i);
  assign rd_sel = decode(s_axil_araddr_i);

  always_comb begin
    wr_merged = read_reg(wr_sel);
    for (int b = 0; b < `ROCE_AXIL_DATA_W/8; b++) begin
      if (s_axil_wstrb_i[b]) wr_merged[8*b +: 8] = s_axil_wdata_i[8*b +: 8];
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (reset_i) begin
      lmac_lo <= '0;
      lmac_hi <= '0;
      rmac_lo <= '0;
      rmac_hi <= '0;
    end else if (wr_en) begin
      case (wr_sel)
        REG_LMAC_LO: lmac_lo <= wr_merged;
        REG_LMAC_HI: lmac_hi <= wr_merged[mac_hi_bits-1:0];
        REG_RMAC_LO: rmac_lo <= wr_merged;
        REG_RMAC_HI: rmac_hi <= wr_merged[mac_hi_bits-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (reset_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_en) bvalid_q <= 1'b1;
      else if (s_axil_bready_i) bvalid_q <= 1'b0;
      if (rd_en) rvalid_q <= 1'b1;
      else if (s_axil_rready_i) rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (wr_en) bresp_q <= (wr_sel == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
    if (rd_en) begin
      rresp_q <= (rd_sel == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
      rdata_q <= read_reg(rd_sel);
    end
  end

  assign s_axil_awready_o = wr_en;
  assign s_axil_wready_o  = wr_en;
  assign s_axil_bvalid_o  = bvalid_q;
  assign s_axil_bresp_o   = bresp_q;
  assign s_axil_arready_o = rd_en;
  assign s_axil_rvalid_o  = rvalid_q;
  assign s_axil_rdata_o   = rdata_q;
  assign s_axil_rresp_o   = rresp_q;

  assign cfg_o.local_mac  = to_net({lmac_hi, lmac_lo});
  assign cfg_o.remote_mac = to_net({rmac_hi, rmac_lo});

endmodule : roce_csr

// File: src/mac_header_insert.sv
`timescale 1ns/1ns
`include "roce_consts.svh"

module mac_header_insert (
  input  logic              axis_aclk_i,
  input  logic              reset_i,
  input  csr_pkg::net_cfg_t cfg_i,
  axis_if.sink              ip_in,
  axis_if.source            eth_out
);

  import stream_pkg::*;

  localparam logic [15:0] eth_type = `ROCE_ETHERTYPE_IPV4;

  typedef enum logic {
    ST_HDR,
    ST_BODY
  } state_e;

  state_e     state;
  axis_beat_t hdr_beat;
  logic       hdr_move, body_end;

  // dst MAC, src MAC, ethertype in wire order
  always_comb begin
    hdr_beat = '0;
    hdr_beat.data[47:0]    = cfg_i.remote_mac;
    hdr_beat.data[95:48]   = cfg_i.local_mac;
    hdr_beat.data[103:96]  = eth_type[15:8];
    hdr_beat.data[111:104] = eth_type[7:0];
    for (int k = 0; k < `ROCE_ETH_HDR_BYTES; k++) begin
      hdr_beat.keep[k] = 1'b1;
    end
    hdr_beat.last = 1'b0;
  end

  always_comb begin
    eth_out.tvalid = ip_in.tvalid;
    if (state == ST_HDR) begin
      // header goes out while the first IP beat waits
      eth_out.tdata  = hdr_beat.data;
      eth_out.tkeep  = hdr_beat.keep;
      eth_out.tlast  = hdr_beat.last;
      ip_in.tready   = 1'b0;
    end else begin
      eth_out.tdata  = ip_in.tdata;
      eth_out.tkeep  = ip_in.tkeep;
      eth_out.tlast  = ip_in.tlast;
      ip_in.tready   = eth_out.tready;
    end
  end

  assign hdr_move = (state == ST_HDR) & eth_out.tvalid & eth_out.tready;
  assign body_end = (state == ST_BODY) & ip_in.tvalid & ip_in.tready & ip_in.tlast;

  always_ff @(posedge axis_aclk_i) begin
    if (reset_i) begin
      state <= ST_HDR;
    end else if (hdr_move) begin
      state <= ST_BODY;
    end else if (body_end) begin
      state <= ST_HDR;
    end
  end

endmodule : mac_header_insert

// File: src/tx_stream_arbiter.sv
`timescale 1ns/1ns
`include "roce_consts.svh"

module tx_stream_arbiter (
  input  logic                         axis_aclk_i,
  input  logic                         reset_i,
  axis_if.sink                         roce_in,
  axis_if.sink                         non_roce_in,
  output logic [`ROCE_AXIS_DATA_W-1:0] m_axis_tdata_o,
  output logic [`ROCE_AXIS_KEEP_W-1:0] m_axis_tkeep_o,
  output logic                         m_axis_tlast_o,
  output logic                         m_axis_tvalid_o,
  input  logic                         m_axis_tready_i
);

  import stream_pkg::*;

  // sel encoding, 0 picks roce_in and 1 picks non_roce_in
  logic       grant_q;
  logic       locked_q;
  logic       sel;
  logic       sel_valid;
  logic       load_ok;
  logic       take;
  axis_beat_t sel_beat;
  axis_beat_t out_q;
  logic       out_valid_q;

  // unlocked, grant_q holds the side with priority
  always_comb begin
    if (locked_q || (roce_in.tvalid && non_roce_in.tvalid)) begin
      sel = grant_q;
    end else begin
      sel = non_roce_in.tvalid;
    end
  end

  always_comb begin
    if (sel) begin
      sel_beat.data = non_roce_in.tdata;
      sel_beat.keep = non_roce_in.tkeep;
      sel_beat.last = non_roce_in.tlast;
      sel_valid     = non_roce_in.tvalid;
    end else begin
      sel_beat.data = roce_in.tdata;
      sel_beat.keep = roce_in.tkeep;
      sel_beat.last = roce_in.tlast;
      sel_valid     = roce_in.tvalid;
    end
  end

  // register empty or draining this cycle
  assign load_ok = ~out_valid_q | m_axis_tready_i;
  assign take    = sel_valid & load_ok;

  assign roce_in.tready     = load_ok & ~sel;
  assign non_roce_in.tready = load_ok & sel;

  always_ff @(posedge axis_aclk_i) begin
    if (reset_i) begin
      grant_q     <= 1'b0;
      locked_q    <= 1'b0;
      out_valid_q <= 1'b0;
    end else if (take) begin
      out_valid_q <= 1'b1;
      locked_q    <= ~sel_beat.last;
      // other side gets priority once the frame ends
      grant_q     <= sel_beat.last ? ~sel : sel;
    end else if (m_axis_tready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (take) out_q <= sel_beat;
  end

  assign m_axis_tdata_o  = out_q.data;
  assign m_axis_tkeep_o  = out_q.keep;
  assign m_axis_tlast_o  = out_q.last;
  assign m_axis_tvalid_o = out_valid_q;

endmodule : tx_stream_arbiter

// File: src/roce_tx_path.sv
`timescale 1ns/1ns
`include "roce_consts.svh"

module roce_tx_path (
  input  logic                           axis_aclk_i,
  input  logic                           reset_i,
  input  logic                           s_axil_awvalid_i,
  input  logic [`ROCE_AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
  output logic                           s_axil_awready_o,
  input  logic                           s_axil_wvalid_i,
  input  logic [`ROCE_AXIL_DATA_W-1:0]   s_axil_wdata_i,
  input  logic [`ROCE_AXIL_DATA_W/8-1:0] s_axil_wstrb_i,
  output logic                           s_axil_wready_o,
  output logic                           s_axil_bvalid_o,
  output logic [1:0]                     s_axil_bresp_o,
  input  logic                           s_axil_bready_i,
  input  logic                           s_axil_arvalid_i,
  input  logic [`ROCE_AXIL_ADDR_W-1:0]   s_axil_araddr_i,
  output logic                           s_axil_arready_o,
  output logic                           s_axil_rvalid_o,
  output logic [`ROCE_AXIL_DATA_W-1:0]   s_axil_rdata_o,
  output logic [1:0]                     s_axil_rresp_o,
  input  logic                           s_axil_rready_i,
  // IP packets from the RoCE stack
  input  logic [`ROCE_AXIS_DATA_W-1:0]   s_roce_axis_tdata_i,
  input  logic [`ROCE_AXIS_KEEP_W-1:0]   s_roce_axis_tkeep_i,
  input  logic                           s_roce_axis_tlast_i,
  input  logic                           s_roce_axis_tvalid_i,
  output logic                           s_roce_axis_tready_o,
  // already framed, bypasses the header step
  input  logic [`ROCE_AXIS_DATA_W-1:0]   s_non_roce_axis_tdata_i,
  input  logic [`ROCE_AXIS_KEEP_W-1:0]   s_non_roce_axis_tkeep_i,
  input  logic                           s_non_roce_axis_tlast_i,
  input  logic                           s_non_roce_axis_tvalid_i,
  output logic                           s_non_roce_axis_tready_o,
  output logic [`ROCE_AXIS_DATA_W-1:0]   m_cmac_axis_tdata_o,
  output logic [`ROCE_AXIS_KEEP_W-1:0]   m_cmac_axis_tkeep_o,
  output logic                           m_cmac_axis_tlast_o,
  output logic                           m_cmac_axis_tvalid_o,
  input  logic                           m_cmac_axis_tready_i
);

  import csr_pkg::*;

  net_cfg_t net_cfg;

  axis_if roce_ip_if ();
  axis_if roce_eth_if ();
  axis_if non_roce_if ();

  assign roce_ip_if.tdata     = s_roce_axis_tdata_i;
  assign roce_ip_if.tkeep     = s_roce_axis_tkeep_i;
  assign roce_ip_if.tlast     = s_roce_axis_tlast_i;
  assign roce_ip_if.tvalid    = s_roce_axis_tvalid_i;
  assign s_roce_axis_tready_o = roce_ip_if.tready;

  assign non_roce_if.tdata        = s_non_roce_axis_tdata_i;
  assign non_roce_if.tkeep        = s_non_roce_axis_tkeep_i;
  assign non_roce_if.tlast        = s_non_roce_axis_tlast_i;
  assign non_roce_if.tvalid       = s_non_roce_axis_tvalid_i;
  assign s_non_roce_axis_tready_o = non_roce_if.tready;

  roce_csr u_roce_csr (.*, .cfg_o(net_cfg));

  mac_header_insert u_mac_header_insert (
    .axis_aclk_i (axis_aclk_i),
    .reset_i     (reset_i),
    .cfg_i       (net_cfg),
    .ip_in       (roce_ip_if.sink),
    .eth_out     (roce_eth_if.source)
  );

  tx_stream_arbiter u_tx_stream_arbiter (
    .axis_aclk_i     (axis_aclk_i),
    .reset_i         (reset_i),
    .roce_in         (roce_eth_if.sink),
    .non_roce_in     (non_roce_if.sink),
    .m_axis_tdata_o  (m_cmac_axis_tdata_o),
    .m_axis_tkeep_o  (m_cmac_axis_tkeep_o),
    .m_axis_tlast_o  (m_cmac_axis_tlast_o),
    .m_axis_tvalid_o (m_cmac_axis_tvalid_o),
    .m_axis_tready_i (m_cmac_axis_tready_i)
  );

endmodule : roce_tx_path

// File: testbench/roce_tx_path_assertions.sv
`timescale 1ns/1ns
`include "roce_consts.svh"

module roce_tx_path_assertions (
  input logic                         axis_aclk_i,
  input logic                         reset_i,
  input logic [`ROCE_AXIS_DATA_W-1:0] m_cmac_axis_tdata_o,
  input logic [`ROCE_AXIS_KEEP_W-1:0] m_cmac_axis_tkeep_o,
  input logic                         m_cmac_axis_tlast_o,
  input logic                         m_cmac_axis_tvalid_o,
  input logic                         m_cmac_axis_tready_i,
  input logic                         s_axil_bvalid_o,
  input logic                         s_axil_bready_i,
  input logic                         s_axil_rvalid_o,
  input logic                         s_axil_rready_i
);

  // read by the testbench at the end
  int fail_count = 0;

  // stalled CMAC beat keeps its content
  cmac_stall_a: assert property (@(posedge axis_aclk_i) disable iff (reset_i)
      m_cmac_axis_tvalid_o && !m_cmac_axis_tready_i |=> m_cmac_axis_tvalid_o &&
      $stable(m_cmac_axis_tdata_o) && $stable(m_cmac_axis_tkeep_o) &&
      $stable(m_cmac_axis_tlast_o))
    else begin
      $error("CMAC beat changed or vanished while stalled");
      fail_count++;
    end

  bvalid_hold_a: assert property (@(posedge axis_aclk_i) disable iff (reset_i)
      s_axil_bvalid_o && !s_axil_bready_i |=> s_axil_bvalid_o)
    else begin
      $error("write response dropped before bready");
      fail_count++;
    end

  rvalid_hold_a: assert property (@(posedge axis_aclk_i) disable iff (reset_i)
      s_axil_rvalid_o && !s_axil_rready_i |=> s_axil_rvalid_o)
    else begin
      $error("read response dropped before rready");
      fail_count++;
    end

  cmac_keep_a: assert property (@(posedge axis_aclk_i) disable iff (reset_i)
      m_cmac_axis_tvalid_o |-> m_cmac_axis_tkeep_o != '0)
    else begin
      $error("CMAC beat valid with empty tkeep");
      fail_count++;
    end

endmodule : roce_tx_path_assertions

bind roce_tx_path roce_tx_path_assertions u_assertions (.*);

// File: testbench/tb_roce_tx_path.sv
`timescale 1ns/1ns
`include "roce_consts.svh"

module tb_roce_tx_path;

  import stream_pkg::*;
  import csr_pkg::*;

  localparam int pkts_per_side = 20;
  // CSR phase plus up to 5 beats a packet, generous factor for back-pressure
  localparam int max_cycles = 200 + pkts_per_side * 2 * 5 * 14;

  logic                           axis_aclk_i, reset_i;
  logic                           s_axil_awvalid_i, s_axil_wvalid_i, s_axil_arvalid_i;
  logic                           s_axil_bready_i, s_axil_rready_i;
  logic [`ROCE_AXIL_ADDR_W-1:0]   s_axil_awaddr_i, s_axil_araddr_i;
  logic [`ROCE_AXIL_DATA_W-1:0]   s_axil_wdata_i, s_axil_rdata_o;
  logic [`ROCE_AXIL_DATA_W/8-1:0] s_axil_wstrb_i;
  logic                           s_axil_awready_o, s_axil_wready_o, s_axil_arready_o;
  logic                           s_axil_bvalid_o, s_axil_rvalid_o;
  logic [1:0]                     s_axil_bresp_o, s_axil_rresp_o;
  axis_data_t                     s_roce_axis_tdata_i, s_non_roce_axis_tdata_i;
  axis_keep_t                     s_roce_axis_tkeep_i, s_non_roce_axis_tkeep_i;
  logic                           s_roce_axis_tlast_i, s_roce_axis_tvalid_i;
  logic                           s_non_roce_axis_tlast_i, s_non_roce_axis_tvalid_i;
  logic                           s_roce_axis_tready_o, s_non_roce_axis_tready_o;
  axis_data_t                     m_cmac_axis_tdata_o;
  axis_keep_t                     m_cmac_axis_tkeep_o;
  logic                           m_cmac_axis_tlast_o, m_cmac_axis_tvalid_o;
  logic                           m_cmac_axis_tready_i;

  int          seed = 18890;
  int          value_errors = 0;
  int          other_errors = 0;
  int          cycle_count = 0;
  int          frames_seen = 0;
  string       test_name = "reset";
  logic [31:0] reg_model [4];
  axis_beat_t  roce_exp_q [$];
  axis_beat_t  non_roce_exp_q [$];
  logic        bp_on = 1'b0;
  logic        alt_check = 1'b0;
  logic        in_frame = 1'b0;
  logic        cur_src, last_src;

  roce_tx_path u_roce_tx_path (.*);

  initial begin
    axis_aclk_i = 1'b0;
    forever #2 axis_aclk_i = ~axis_aclk_i;
  end

  always @(posedge axis_aclk_i) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      $display("timeout after %0d cycles, traffic never finished", cycle_count);
      print_error_counts();
      $display("sim failed");
      $finish;
    end
  end

  // CMAC ready, random only while bp_on
  always @(posedge axis_aclk_i) begin
    #1;
    m_cmac_axis_tready_i = bp_on ? 1'($random(seed)) : 1'b1;
  end

  // dst MAC, src MAC, ethertype, most significant byte first on the wire
  function automatic axis_beat_t expected_header(input logic [47:0] local_mac,
                                                 input logic [47:0] remote_mac);
    axis_beat_t hdr;
    hdr = '0;
    for (int b = 0; b < 6; b++) begin
      hdr.data[8*b +: 8]     = remote_mac[8*(5-b) +: 8];
      hdr.data[8*(b+6) +: 8] = local_mac[8*(5-b) +: 8];
    end
    hdr.data[8*12 +: 8] = 8'h08;
    hdr.data[8*13 +: 8] = 8'h00;
    hdr.keep = 16'h3FFF;
    return hdr;
  endfunction

  function automatic bit is_mapped(input logic [31:0] addr);
    return addr < 32'h10 && addr[1:0] == 2'b00;
  endfunction

  task automatic print_error_counts();
    $display("errors: %0d value, %0d protocol, %0d assertion", value_errors, other_errors,
             u_roce_tx_path.u_assertions.fail_count);
  endtask

  task automatic check_value(input string what, input logic [144:0] exp,
                             input logic [144:0] act);
    assert (act === exp) else begin
      $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      value_errors++;
    end
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    logic [1:0] exp_resp;
    exp_resp = RESP_SLVERR;
    if (is_mapped(addr)) begin
      exp_resp = RESP_OKAY;
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) reg_model[addr[3:2]][8*b +: 8] = data[8*b +: 8];
      end
      // high halves keep 16 bits
      if (addr[2]) reg_model[addr[3:2]][31:16] = '0;
    end
    s_axil_awaddr_i  = addr;
    s_axil_wdata_i   = data;
    s_axil_wstrb_i   = strb;
    s_axil_awvalid_i = 1'b1;
    s_axil_wvalid_i  = 1'b1;
    do @(negedge axis_aclk_i); while (!(s_axil_awready_o && s_axil_wready_o));
    @(posedge axis_aclk_i);
    #1;
    s_axil_awvalid_i = 1'b0;
    s_axil_wvalid_i  = 1'b0;
    do @(negedge axis_aclk_i); while (!s_axil_bvalid_o);
    check_value("bresp", exp_resp, s_axil_bresp_o);
    // response waits a cycle before it is taken
    @(posedge axis_aclk_i);
    #1;
    s_axil_bready_i = 1'b1;
    @(posedge axis_aclk_i);
    #1;
    s_axil_bready_i = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr);
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    exp_data = '0;
    exp_resp = RESP_SLVERR;
    if (is_mapped(addr)) begin
      exp_data = reg_model[addr[3:2]];
      exp_resp = RESP_OKAY;
    end
    s_axil_araddr_i  = addr;
    s_axil_arvalid_i = 1'b1;
    do @(negedge axis_aclk_i); while (!s_axil_arready_o);
    @(posedge axis_aclk_i);
    #1;
    s_axil_arvalid_i = 1'b0;
    do @(negedge axis_aclk_i); while (!s_axil_rvalid_o);
    check_value($sformatf("rdata at 0x%0h", addr), exp_data, s_axil_rdata_o);
    check_value($sformatf("rresp at 0x%0h", addr), exp_resp, s_axil_rresp_o);
    // response waits a cycle before it is taken
    @(posedge axis_aclk_i);
    #1;
    s_axil_rready_i = 1'b1;
    @(posedge axis_aclk_i);
    #1;
    s_axil_rready_i = 1'b0;
  endtask

  task automatic drive_beat(input bit non_roce, input axis_beat_t beat, input logic valid);
    if (non_roce) begin
      s_non_roce_axis_tdata_i  = beat.data;
      s_non_roce_axis_tkeep_i  = beat.keep;
      s_non_roce_axis_tlast_i  = beat.last;
      s_non_roce_axis_tvalid_i = valid;
    end else begin
      s_roce_axis_tdata_i  = beat.data;
      s_roce_axis_tkeep_i  = beat.keep;
      s_roce_axis_tlast_i  = beat.last;
      s_roce_axis_tvalid_i = valid;
    end
  endtask

  task automatic send_packet(input bit non_roce, input int len);
    axis_beat_t beat;
    logic       moved;
    int         nbytes;
    if (!non_roce) begin
      roce_exp_q.push_back(expected_header({reg_model[1][15:0], reg_model[0]},
                                           {reg_model[3][15:0], reg_model[2]}));
    end
    for (int i = 0; i < len; i++) begin
      beat.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
      beat.keep = '1;
      beat.last = (i == len - 1);
      // bypassed frames always open with a full beat
      if (beat.last && !(non_roce && i == 0)) begin
        nbytes    = 1 + $unsigned($random(seed)) % 16;
        beat.keep = 16'((32'd1 << nbytes) - 1);
      end
      if (non_roce) non_roce_exp_q.push_back(beat);
      else roce_exp_q.push_back(beat);
      drive_beat(non_roce, beat, 1'b1);
      do begin
        @(negedge axis_aclk_i);
        moved = non_roce ? s_non_roce_axis_tready_o : s_roce_axis_tready_o;
      end while (!moved);
      @(posedge axis_aclk_i);
      #1;
    end
    drive_beat(non_roce, '0, 1'b0);
  endtask

  task automatic wait_drained();
    while (roce_exp_q.size() > 0 || non_roce_exp_q.size() > 0)
      @(negedge axis_aclk_i);
    @(posedge axis_aclk_i);
    #1;
  endtask

  initial begin : compare_outputs
    axis_beat_t act;
    forever begin
      @(negedge axis_aclk_i);
      if (m_cmac_axis_tvalid_o && m_cmac_axis_tready_i) begin
        act = {m_cmac_axis_tdata_o, m_cmac_axis_tkeep_o, m_cmac_axis_tlast_o};
        if (!in_frame) begin
          // RoCE frames open with the 14-byte header
          cur_src = (act.keep == '1);
          if (alt_check && frames_seen > 0) check_value("grant order", !last_src, cur_src);
          last_src = cur_src;
          frames_seen++;
        end
        assert (cur_src ? non_roce_exp_q.size() > 0 : roce_exp_q.size() > 0) else begin
          $display("output beat arrived while no frame was expected from its source");
          other_errors++;
        end
        if (cur_src && non_roce_exp_q.size() > 0)
          check_value("non-RoCE beat", non_roce_exp_q.pop_front(), act);
        else if (!cur_src && roce_exp_q.size() > 0)
          check_value("RoCE beat", roce_exp_q.pop_front(), act);
        in_frame = !act.last;
      end
    end
  end

  initial begin : run_tests
    s_axil_awvalid_i = 1'b0;
    s_axil_awaddr_i  = '0;
    s_axil_wvalid_i  = 1'b0;
    s_axil_wdata_i   = '0;
    s_axil_wstrb_i   = '0;
    s_axil_bready_i  = 1'b0;
    s_axil_arvalid_i = 1'b0;
    s_axil_araddr_i  = '0;
    s_axil_rready_i  = 1'b0;
    m_cmac_axis_tready_i = 1'b1;
    drive_beat(1'b0, '0, 1'b0);
    drive_beat(1'b1, '0, 1'b0);
    for (int i = 0; i < 4; i++) reg_model[i] = '0;
    reset_i = 1'b1;
    repeat (2) @(posedge axis_aclk_i);
    #1;
    reset_i = 1'b0;

    check_value("cmac tvalid", 1'b0, m_cmac_axis_tvalid_o);
    check_value("bvalid", 1'b0, s_axil_bvalid_o);
    check_value("rvalid", 1'b0, s_axil_rvalid_o);
    for (int a = 0; a < 16; a += 4) axil_read(a);

    test_name = "strobes";
    axil_write(`ROCE_REG_LMAC_LO, 32'h1122_3344, 4'hF);
    axil_write(`ROCE_REG_LMAC_LO, 32'hAABB_CCDD, 4'b0101);
    axil_write(`ROCE_REG_LMAC_HI, 32'hDEAD_0A0B, 4'hF);
    axil_write(`ROCE_REG_RMAC_LO, 32'h5566_7788, 4'b1100);
    axil_write(`ROCE_REG_RMAC_LO, 32'h0000_99EE, 4'b0011);
    axil_write(`ROCE_REG_RMAC_HI, 32'h1234_F00D, 4'b0110);
    for (int a = 0; a < 16; a += 4) axil_read(a);

    test_name = "unmapped";
    axil_write(32'h20, 32'hFFFF_FFFF, 4'hF);
    axil_read(32'h20);
    for (int a = 0; a < 16; a += 4) axil_read(a);

    test_name = "roce frame";
    send_packet(1'b0, 3);
    wait_drained();

    test_name = "bypass frame";
    send_packet(1'b1, 2);
    wait_drained();

    test_name = "merge";
    frames_seen = 0;
    alt_check   = 1'b1;
    @(negedge axis_aclk_i);
    bp_on = 1'b1;
    @(posedge axis_aclk_i);
    #1;
    fork
      repeat (pkts_per_side) send_packet(1'b0, 1 + $unsigned($random(seed)) % 4);
      repeat (pkts_per_side) send_packet(1'b1, 1 + $unsigned($random(seed)) % 4);
    join
    wait_drained();
    @(negedge axis_aclk_i);
    bp_on     = 1'b0;
    alt_check = 1'b0;
    check_value("frame count", 2 * pkts_per_side, frames_seen);
    check_value("frame left open", 1'b0, in_frame);

    print_error_counts();
    if (value_errors + other_errors + u_roce_tx_path.u_assertions.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule : tb_roce_tx_path

// File: all.f
+incdir+include
src/stream_pkg.sv
src/csr_pkg.sv
src/axis_if.sv
src/roce_csr.sv
src/mac_header_insert.sv
src/tx_stream_arbiter.sv
src/roce_tx_path.sv
testbench/roce_tx_path_assertions.sv
testbench/tb_roce_tx_path.sv
